// File: hdl/pkt_pkg.sv
/* Shared widths, fault and verdict enums, and the payload byte rule
   for the packet loopback subsystem */

package pkt_pkg;

    //////////////////////////////////////////////////
    // Widths

    // Four destinations
    localparam int DEST_W = 2;

    // Length field in the header, bytes
    localparam int LEN_W = 16;

    // Per-destination sequence number
    localparam int SEQ_W = 8;

    //////////////////////////////////////////////////
    // Enums

    // Generator fault commands
    typedef enum logic [1:0] {
        fault_none = 2'd0,
        fault_data = 2'd1,   // bit 0 of payload byte 0 inverted
        fault_len  = 2'd2,   // header claims one byte too many
        fault_seq  = 2'd3    // sequence skips ahead by one
    } fault_e;

    // Checker verdicts
    typedef enum logic [1:0] {
        chk_ok       = 2'd0,
        chk_len_err  = 2'd1,
        chk_seq_err  = 2'd2,
        chk_data_err = 2'd3
    } check_e;

    //////////////////////////////////////////////////
    // Payload rule

    // Byte index + 7 * seq + 31 * dest, low eight bits
    function automatic logic [7:0] payload_byte(
        input logic [LEN_W-1:0]  idx,
        input logic [SEQ_W-1:0]  seq,
        input logic [DEST_W-1:0] dest
    );
        logic [LEN_W-1:0] sum;
        sum = idx + LEN_W'(seq) * LEN_W'(7) + LEN_W'(dest) * LEN_W'(31);
        return sum[7:0];
    endfunction

endpackage

// File: hdl/pkt_generator.sv
/* Command-driven packet source: header beat, rule-based payload,
   per-destination sequence numbers and fault injection */

`timescale 1ns/1ns

module pkt_generator #(
    parameter int DATA_BYTES = 4,
    parameter int MAX_LEN    = 64
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  logic [pkt_pkg::DEST_W-1:0]     cmd_dest,
    input  logic [pkt_pkg::LEN_W-1:0]      cmd_len,
    input  pkt_pkg::fault_e                cmd_fault,
    output logic                           m_valid,
    input  logic                           m_ready,
    output logic [8*DATA_BYTES-1:0]        m_data,
    output logic [DATA_BYTES-1:0]          m_keep,
    output logic                           m_last,
    output logic [pkt_pkg::DEST_W-1:0]     m_dest
);

    localparam int DW       = 8 * DATA_BYTES;
    localparam int NUM_DEST = 2 ** pkt_pkg::DEST_W;
    // Byte offset only has to reach past the longest packet
    localparam int OFS_W    = $clog2(MAX_LEN + DATA_BYTES + 1);

    typedef enum logic [1:0] {
        gen_idle    = 2'd0,
        gen_header  = 2'd1,
        gen_payload = 2'd2
    } gen_state_e;

    gen_state_e                   state;
    logic [pkt_pkg::SEQ_W-1:0]    seq_cnt [NUM_DEST];
    logic [pkt_pkg::SEQ_W-1:0]    cmd_seq;
    logic                         cmd_fire;
    logic                         beat_fire;

    // Packet being sent
    logic [pkt_pkg::DEST_W-1:0]   dest_q;
    logic [pkt_pkg::LEN_W-1:0]    len_q;
    logic [pkt_pkg::LEN_W-1:0]    claim_q;
    logic [pkt_pkg::SEQ_W-1:0]    seq_q;
    pkt_pkg::fault_e              fault_q;
    logic [OFS_W-1:0]             offset;

    logic [DW-1:0]                hdr_word;
    logic [DW-1:0]                pay_word;
    logic [DATA_BYTES-1:0]        pay_keep;

    assign cmd_ready = (state == gen_idle);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign beat_fire = m_valid && m_ready;

    // fault_seq skips one number before this packet
    assign cmd_seq = seq_cnt[cmd_dest] + pkt_pkg::SEQ_W'(cmd_fault == pkt_pkg::fault_seq);

    //////////////////////////////////////////////////
    // Beat formatting

    // Length in lanes 0-1, sequence in lane 2
    assign hdr_word = DW'({seq_q, claim_q});

    for (genvar i = 0; i < DATA_BYTES; i++) begin : g_lane
        logic [pkt_pkg::LEN_W-1:0] idx;
        logic                      flip;

        assign idx  = pkt_pkg::LEN_W'(offset) + pkt_pkg::LEN_W'(i);
        assign flip = (fault_q == pkt_pkg::fault_data) && (idx == '0);
        assign pay_word[8*i +: 8] = pkt_pkg::payload_byte(idx, seq_q, dest_q) ^ {7'd0, flip};
        assign pay_keep[i] = (idx < len_q);
    end

    assign m_valid = (state != gen_idle);
    assign m_data  = (state == gen_header) ? hdr_word : pay_word;
    assign m_keep  = (state == gen_header) ? '1 : pay_keep;
    assign m_last  = (state == gen_payload) &&
                     (pkt_pkg::LEN_W'(offset) + pkt_pkg::LEN_W'(DATA_BYTES) >= len_q);
    assign m_dest  = dest_q;

    //////////////////////////////////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= gen_idle;
            for (int d = 0; d < NUM_DEST; d++) begin
                seq_cnt[d] <= '0;
            end
        end else begin
            case (state)
                gen_idle: begin
                    if (cmd_fire) begin
                        state             <= gen_header;
                        seq_cnt[cmd_dest] <= cmd_seq + 1'b1;
                    end
                end
                gen_header: begin
                    if (beat_fire) begin
                        state <= gen_payload;
                    end
                end
                default: begin
                    if (beat_fire && m_last) begin
                        state <= gen_idle;
                    end
                end
            endcase
        end
    end

    // Command latch and byte offset
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            dest_q  <= cmd_dest;
            len_q   <= cmd_len;
            claim_q <= (cmd_fault == pkt_pkg::fault_len) ? cmd_len + 1'b1 : cmd_len;
            seq_q   <= cmd_seq;
            fault_q <= cmd_fault;
            offset  <= '0;
        end else if (beat_fire && state == gen_payload) begin
            offset <= offset + OFS_W'(DATA_BYTES);
        end
    end

    // A stalled beat holds until it moves
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable({m_data, m_keep, m_last, m_dest})
    );

endmodule

// File: hdl/pkt_fifo.sv
/* Synchronous stream FIFO for data, keep, last and dest */

`timescale 1ns/1ns

module pkt_fifo #(
    parameter int DATA_BYTES = 4,
    parameter int DEPTH      = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           s_valid,
    output logic                           s_ready,
    input  logic [8*DATA_BYTES-1:0]        s_data,
    input  logic [DATA_BYTES-1:0]          s_keep,
    input  logic                           s_last,
    input  logic [pkt_pkg::DEST_W-1:0]     s_dest,
    output logic                           m_valid,
    input  logic                           m_ready,
    output logic [8*DATA_BYTES-1:0]        m_data,
    output logic [DATA_BYTES-1:0]          m_keep,
    output logic                           m_last,
    output logic [pkt_pkg::DEST_W-1:0]     m_dest
);

    localparam int W     = 8 * DATA_BYTES + DATA_BYTES + 1 + pkt_pkg::DEST_W;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [W-1:0]     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Full FIFO still takes a beat when one leaves
    assign s_ready = (count != CNT_W'(DEPTH)) || m_ready;
    assign m_valid = (count != '0);
    assign wr_en   = s_valid && s_ready;
    assign rd_en   = m_valid && m_ready;

    assign {m_dest, m_last, m_keep, m_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {s_dest, s_last, s_keep, s_data};
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) count <= CNT_W'(DEPTH)
    );

endmodule

// File: hdl/pkt_checker.sv
/* Packet sink: checks length, sequence and payload per destination,
   reports one verdict per packet and counts good and bad packets */

`timescale 1ns/1ns

module pkt_checker #(
    parameter int DATA_BYTES = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           s_valid,
    output logic                           s_ready,
    input  logic [8*DATA_BYTES-1:0]        s_data,
    input  logic [DATA_BYTES-1:0]          s_keep,
    input  logic                           s_last,
    input  logic [pkt_pkg::DEST_W-1:0]     s_dest,
    input  logic                           sink_stall,
    output logic                           res_valid,
    output logic [pkt_pkg::DEST_W-1:0]     res_dest,
    output logic [pkt_pkg::LEN_W-1:0]      res_len,
    output logic [pkt_pkg::SEQ_W-1:0]      res_seq,
    output pkt_pkg::check_e                res_check,
    output logic [15:0]                    good_count,
    output logic [15:0]                    bad_count
);

    localparam int NUM_DEST = 2 ** pkt_pkg::DEST_W;
    localparam int BB_W     = $clog2(DATA_BYTES + 1);

    typedef enum logic {
        chk_header  = 1'b0,
        chk_payload = 1'b1
    } chk_state_e;

    chk_state_e                  state;
    logic                        beat_fire;
    logic [pkt_pkg::SEQ_W-1:0]   exp_seq [NUM_DEST];

    // Header capture and running packet state
    logic [pkt_pkg::LEN_W-1:0]   claim_len;
    logic [pkt_pkg::SEQ_W-1:0]   rx_seq;
    logic [pkt_pkg::DEST_W-1:0]  rx_dest;
    logic [pkt_pkg::LEN_W-1:0]   byte_cnt;
    logic                        data_bad;

    // Current beat
    logic [BB_W-1:0]             beat_bytes;
    logic                        beat_bad;
    logic [pkt_pkg::LEN_W-1:0]   total_len;
    pkt_pkg::check_e             verdict;

    assign s_ready   = !sink_stall;
    assign beat_fire = s_valid && s_ready;

    //////////////////////////////////////////////////
    // Per-beat byte count and compare

    always_comb begin
        beat_bytes = '0;
        beat_bad   = 1'b0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (s_keep[i]) begin
                beat_bytes = beat_bytes + 1'b1;
                if (s_data[8*i +: 8] != pkt_pkg::payload_byte(
                        byte_cnt + pkt_pkg::LEN_W'(i), rx_seq, rx_dest)) begin
                    beat_bad = 1'b1;
                end
            end
        end
    end

    assign total_len = byte_cnt + pkt_pkg::LEN_W'(beat_bytes);

    // Length first, then sequence, then data
    always_comb begin
        if (total_len != claim_len) begin
            verdict = pkt_pkg::chk_len_err;
        end else if (rx_seq != exp_seq[rx_dest]) begin
            verdict = pkt_pkg::chk_seq_err;
        end else if (data_bad || beat_bad) begin
            verdict = pkt_pkg::chk_data_err;
        end else begin
            verdict = pkt_pkg::chk_ok;
        end
    end

    //////////////////////////////////////////////////
    // Control, expected sequence and counters

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= chk_header;
            res_valid  <= 1'b0;
            good_count <= '0;
            bad_count  <= '0;
            for (int d = 0; d < NUM_DEST; d++) begin
                exp_seq[d] <= '0;
            end
        end else begin
            res_valid <= 1'b0;
            if (beat_fire) begin
                if (state == chk_header) begin
                    state <= chk_payload;
                end else if (s_last) begin
                    state     <= chk_header;
                    res_valid <= 1'b1;
                    if (verdict == pkt_pkg::chk_ok) begin
                        good_count <= good_count + 1'b1;
                    end else begin
                        bad_count <= bad_count + 1'b1;
                    end
                    // Resync to whatever arrived
                    exp_seq[rx_dest] <= rx_seq + 1'b1;
                end
            end
        end
    end

    // Packet fields and result payload
    always_ff @(posedge clk) begin
        if (beat_fire) begin
            if (state == chk_header) begin
                claim_len <= s_data[pkt_pkg::LEN_W-1:0];
                rx_seq    <= s_data[pkt_pkg::LEN_W +: pkt_pkg::SEQ_W];
                rx_dest   <= s_dest;
                byte_cnt  <= '0;
                data_bad  <= 1'b0;
            end else begin
                byte_cnt <= total_len;
                data_bad <= data_bad || beat_bad;
                if (s_last) begin
                    res_dest  <= rx_dest;
                    res_len   <= total_len;
                    res_seq   <= rx_seq;
                    res_check <= verdict;
                end
            end
        end
    end

    a_keep_contig: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat_fire |-> s_keep[0] && ((s_keep & (s_keep + 1'b1)) == '0)
    );

    // Generator never ends a packet on its header
    a_hdr_not_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        s_valid && state == chk_header |-> !s_last
    );

endmodule

// File: hdl/pkt_loopback_top.sv
/* Loopback top: generator into FIFO into checker */

`timescale 1ns/1ns

module pkt_loopback_top #(
    parameter int DATA_BYTES = 4,
    parameter int MAX_LEN    = 64,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  logic [pkt_pkg::DEST_W-1:0]     cmd_dest,
    input  logic [pkt_pkg::LEN_W-1:0]      cmd_len,
    input  pkt_pkg::fault_e                cmd_fault,
    input  logic                           sink_stall,
    output logic                           res_valid,
    output logic [pkt_pkg::DEST_W-1:0]     res_dest,
    output logic [pkt_pkg::LEN_W-1:0]      res_len,
    output logic [pkt_pkg::SEQ_W-1:0]      res_seq,
    output pkt_pkg::check_e                res_check,
    output logic [15:0]                    good_count,
    output logic [15:0]                    bad_count
);

    // Generator to FIFO
    logic                           gen_valid;
    logic                           gen_ready;
    logic [8*DATA_BYTES-1:0]        gen_data;
    logic [DATA_BYTES-1:0]          gen_keep;
    logic                           gen_last;
    logic [pkt_pkg::DEST_W-1:0]     gen_dest;

    // FIFO to checker
    logic                           fifo_valid;
    logic                           fifo_ready;
    logic [8*DATA_BYTES-1:0]        fifo_data;
    logic [DATA_BYTES-1:0]          fifo_keep;
    logic                           fifo_last;
    logic [pkt_pkg::DEST_W-1:0]     fifo_dest;

    pkt_generator #(
        .DATA_BYTES ( DATA_BYTES ),
        .MAX_LEN    ( MAX_LEN    )
    ) u_gen (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cmd_valid ( cmd_valid ),
        .cmd_ready ( cmd_ready ),
        .cmd_dest  ( cmd_dest  ),
        .cmd_len   ( cmd_len   ),
        .cmd_fault ( cmd_fault ),
        .m_valid   ( gen_valid ),
        .m_ready   ( gen_ready ),
        .m_data    ( gen_data  ),
        .m_keep    ( gen_keep  ),
        .m_last    ( gen_last  ),
        .m_dest    ( gen_dest  )
    );

    pkt_fifo #(
        .DATA_BYTES ( DATA_BYTES ),
        .DEPTH      ( FIFO_DEPTH )
    ) u_fifo (
        .clk     ( clk        ),
        .rst_n   ( rst_n      ),
        .s_valid ( gen_valid  ),
        .s_ready ( gen_ready  ),
        .s_data  ( gen_data   ),
        .s_keep  ( gen_keep   ),
        .s_last  ( gen_last   ),
        .s_dest  ( gen_dest   ),
        .m_valid ( fifo_valid ),
        .m_ready ( fifo_ready ),
        .m_data  ( fifo_data  ),
        .m_keep  ( fifo_keep  ),
        .m_last  ( fifo_last  ),
        .m_dest  ( fifo_dest  )
    );

    pkt_checker #(
        .DATA_BYTES ( DATA_BYTES )
    ) u_chk (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .s_valid    ( fifo_valid ),
        .s_ready    ( fifo_ready ),
        .s_data     ( fifo_data  ),
        .s_keep     ( fifo_keep  ),
        .s_last     ( fifo_last  ),
        .s_dest     ( fifo_dest  ),
        .sink_stall ( sink_stall ),
        .res_valid  ( res_valid  ),
        .res_dest   ( res_dest   ),
        .res_len    ( res_len    ),
        .res_seq    ( res_seq    ),
        .res_check  ( res_check  ),
        .good_count ( good_count ),
        .bad_count  ( bad_count  )
    );

endmodule

// File: tests/pkt_loopback_tb.sv
/* Testbench for the packet loopback subsystem: clock, reset, stimulus,
   expected-result queue, result assertions and watchdog */

`timescale 1ns/1ns

module pkt_loopback_tb;

    localparam int DATA_BYTES = 4;
    localparam int MAX_LEN    = 64;
    localparam int FIFO_DEPTH = 8;
    localparam int NUM_DEST   = 2 ** pkt_pkg::DEST_W;
    localparam int CLEAN_LEN [12] = '{1, 2, 3, 4, 5, 7, 8, 13, 31, 33, 63, 64};

    // One expected result per accepted command
    typedef struct packed {
        logic [pkt_pkg::DEST_W-1:0] dest;
        logic [pkt_pkg::LEN_W-1:0]  len;
        logic [pkt_pkg::SEQ_W-1:0]  seq;
        pkt_pkg::check_e            check;
    } exp_rec_t;

    logic                        clk;
    logic                        rst_n;
    logic                        cmd_valid;
    logic                        cmd_ready;
    logic [pkt_pkg::DEST_W-1:0]  cmd_dest;
    logic [pkt_pkg::LEN_W-1:0]   cmd_len;
    pkt_pkg::fault_e             cmd_fault;
    logic                        sink_stall;
    logic                        res_valid;
    logic [pkt_pkg::DEST_W-1:0]  res_dest;
    logic [pkt_pkg::LEN_W-1:0]   res_len;
    logic [pkt_pkg::SEQ_W-1:0]   res_seq;
    pkt_pkg::check_e             res_check;
    logic [15:0]                 good_count;
    logic [15:0]                 bad_count;

    // Reference model state
    exp_rec_t                    exp_q [$];
    exp_rec_t                    exp_head;
    int                          pending;
    logic [pkt_pkg::SEQ_W-1:0]   gen_seq [NUM_DEST];
    logic [pkt_pkg::SEQ_W-1:0]   chk_seq [NUM_DEST];
    int                          model_good;
    int                          model_bad;
    int                          cmd_count;
    int                          stall_pct;
    string                       test_name;

    pkt_loopback_top #(
        .DATA_BYTES ( DATA_BYTES ),
        .MAX_LEN    ( MAX_LEN    ),
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) UUT (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cmd_valid  ( cmd_valid  ),
        .cmd_ready  ( cmd_ready  ),
        .cmd_dest   ( cmd_dest   ),
        .cmd_len    ( cmd_len    ),
        .cmd_fault  ( cmd_fault  ),
        .sink_stall ( sink_stall ),
        .res_valid  ( res_valid  ),
        .res_dest   ( res_dest   ),
        .res_len    ( res_len    ),
        .res_seq    ( res_seq    ),
        .res_check  ( res_check  ),
        .good_count ( good_count ),
        .bad_count  ( bad_count  )
    );

    always #2 clk = ~clk;

    // Random back-pressure at the sink
    task automatic drive_stall();
        forever begin
            @(negedge clk);
            sink_stall <= (int'($urandom_range(99, 0)) < stall_pct);
        end
    endtask

    //////////////////////////////////////////////////
    // Failure reporting and model helpers

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic fail_value(input string what, input int expected, input int actual);
        $display("ERR %s: %s expected %0d actual %0d", test_name, what, expected, actual);
        stop_failed();
    endtask

    task automatic fail_plain(input string why);
        $display("%s: %s", test_name, why);
        stop_failed();
    endtask

    function automatic void refresh_head();
        pending  = exp_q.size();
        exp_head = (pending != 0) ? exp_q[0] : '0;
    endfunction

    // Expected sequence and verdict for one command
    function automatic void predict(input logic [pkt_pkg::DEST_W-1:0] dest,
                                    input logic [pkt_pkg::LEN_W-1:0] len,
                                    input pkt_pkg::fault_e fault);
        exp_rec_t rec;
        rec.dest = dest;
        rec.len  = len;
        rec.seq  = gen_seq[dest];
        if (fault == pkt_pkg::fault_seq) begin
            rec.seq = rec.seq + 1'b1;
        end
        if (fault == pkt_pkg::fault_len) begin
            rec.check = pkt_pkg::chk_len_err;
        end else if (rec.seq != chk_seq[dest]) begin
            rec.check = pkt_pkg::chk_seq_err;
        end else if (fault == pkt_pkg::fault_data) begin
            rec.check = pkt_pkg::chk_data_err;
        end else begin
            rec.check = pkt_pkg::chk_ok;
        end
        gen_seq[dest] = rec.seq + 1'b1;
        chk_seq[dest] = rec.seq + 1'b1;
        if (rec.check == pkt_pkg::chk_ok) begin
            model_good++;
        end else begin
            model_bad++;
        end
        exp_q.push_back(rec);
        refresh_head();
    endfunction

    task automatic send_cmd(input logic [pkt_pkg::DEST_W-1:0] dest,
                            input logic [pkt_pkg::LEN_W-1:0] len,
                            input pkt_pkg::fault_e fault);
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        cmd_valid = 1'b1;
        cmd_dest  = dest;
        cmd_len   = len;
        cmd_fault = fault;
        cmd_count++;
        // Ready holds until the next edge, so this command is taken there
        predict(dest, len, fault);
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending != 0 || !cmd_ready) begin
            @(negedge clk);
        end
    endtask

    // Retire the front record once its result has been checked
    always @(posedge clk) begin
        if (rst_n && res_valid && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    //////////////////////////////////////////////////
    // Result checks

    a_reset_vals: assert property (@(posedge clk)
        !rst_n |=> cmd_ready && !res_valid && good_count == '0 && bad_count == '0)
        else fail_plain("outputs not at their reset values");

    a_res_expected: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> pending != 0)
        else fail_plain("result arrived with no command outstanding");

    a_res_dest: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_dest == exp_head.dest)
        else fail_value("res_dest", $sampled(exp_head.dest), $sampled(res_dest));

    a_res_len: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_len == exp_head.len)
        else fail_value("res_len", $sampled(exp_head.len), $sampled(res_len));

    a_res_seq: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_seq == exp_head.seq)
        else fail_value("res_seq", $sampled(exp_head.seq), $sampled(res_seq));

    a_res_check: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_check == exp_head.check)
        else fail_value("res_check", $sampled(exp_head.check), $sampled(res_check));

    // Budget grows with every command issued
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 1000 + 200 * cmd_count) begin
            @(posedge clk);
            cycles++;
        end
        fail_plain("timeout, the DUT stopped making progress");
    end

    initial begin : stimulus
        void'($urandom(32'hb92d_4872));
        clk        = 1'b0;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_dest   = '0;
        cmd_len    = '0;
        cmd_fault  = pkt_pkg::fault_none;
        sink_stall = 1'b0;
        stall_pct  = 0;
        model_good = 0;
        model_bad  = 0;
        cmd_count  = 0;
        test_name  = "reset";
        for (int d = 0; d < NUM_DEST; d++) begin
            gen_seq[d] = '0;
            chk_seq[d] = '0;
        end
        refresh_head();
        fork
            drive_stall();
        join_none
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        test_name = "clean";
        for (int d = 0; d < NUM_DEST; d++) begin
            for (int i = 0; i < 12; i++) begin
                send_cmd(d[pkt_pkg::DEST_W-1:0], pkt_pkg::LEN_W'(CLEAN_LEN[i]),
                         pkt_pkg::fault_none);
            end
        end
        wait_drain();

        test_name = "stall_burst";
        stall_pct = 50;
        for (int n = 0; n < 40; n++) begin
            send_cmd(pkt_pkg::DEST_W'($urandom_range(NUM_DEST - 1, 0)),
                     pkt_pkg::LEN_W'($urandom_range(MAX_LEN, 1)), pkt_pkg::fault_none);
        end
        wait_drain();
        stall_pct = 0;

        test_name = "fault_data";
        send_cmd(1, 17, pkt_pkg::fault_data);
        send_cmd(1, 9, pkt_pkg::fault_none);
        send_cmd(3, 1, pkt_pkg::fault_data);
        send_cmd(3, 4, pkt_pkg::fault_none);
        wait_drain();

        test_name = "fault_len";
        send_cmd(0, 10, pkt_pkg::fault_len);
        send_cmd(2, 64, pkt_pkg::fault_len);
        send_cmd(0, 12, pkt_pkg::fault_none);
        wait_drain();

        test_name = "fault_seq";
        send_cmd(1, 20, pkt_pkg::fault_seq);
        send_cmd(1, 6, pkt_pkg::fault_none);
        send_cmd(3, 8, pkt_pkg::fault_seq);
        send_cmd(3, 8, pkt_pkg::fault_none);
        wait_drain();

        test_name = "counters";
        assert (good_count == 16'(model_good))
            else fail_value("good_count", model_good, good_count);
        assert (bad_count == 16'(model_bad))
            else fail_value("bad_count", model_bad, bad_count);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: all.f
hdl/pkt_pkg.sv
hdl/pkt_generator.sv
hdl/pkt_fifo.sv
hdl/pkt_checker.sv
hdl/pkt_loopback_top.sv
tests/pkt_loopback_tb.sv

// File: Bender.yml
package:
  name: pkt_loopback

sources:
  # Design sources in compile order
  - files:
      - hdl/pkt_pkg.sv
      - hdl/pkt_generator.sv
      - hdl/pkt_fifo.sv
      - hdl/pkt_checker.sv
      - hdl/pkt_loopback_top.sv

  # Testbench, top module pkt_loopback_tb
  - target: test
    files:
      - tests/pkt_loopback_tb.sv
